//--- logic/data_cache_params.svh
//----------------------------------------------------------
// Data cache geometry
// Ways, sets, word and address widths of the cache, and the
// field widths that follow from them
//----------------------------------------------------------

`ifndef DATA_CACHE_PARAMS_SVH
`define DATA_CACHE_PARAMS_SVH

// Associativity and number of sets
`define DC_WAYS 4
`define DC_SETS 16

// One line holds a single word under a word address
`define DC_WORD_WIDTH 32
`define DC_ADDR_WIDTH 16

// Derived field widths of the word address
`define DC_INDEX_BITS $clog2(`DC_SETS)
`define DC_TAG_BITS (`DC_ADDR_WIDTH - `DC_INDEX_BITS)

// Width of a way number
`define DC_WAY_BITS $clog2(`DC_WAYS)

`endif

//--- logic/cache_types_pkg.sv
//----------------------------------------------------------
// Cache datapath types
// Vector types for the words, addresses and address fields
//----------------------------------------------------------

`include "data_cache_params.svh"

package cache_types_pkg;

    // A data word as seen by the CPU and the memory
    typedef logic [`DC_WORD_WIDTH-1:0] word_t;

    // A word address
    typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;

    // Upper address bits stored next to each line
    typedef logic [`DC_TAG_BITS-1:0] tag_t;

    // Lower address bits that pick the set
    typedef logic [`DC_INDEX_BITS-1:0] index_t;

    // Selects one of the ways
    typedef logic [`DC_WAY_BITS-1:0] way_idx_t;

endpackage : cache_types_pkg

//--- logic/cache_ctrl_pkg.sv
//----------------------------------------------------------
// Cache controller types
// States of the request sequencer
//----------------------------------------------------------

package cache_ctrl_pkg;

    // IDLE waits for a request, LOOKUP checks the tags
    // WRITEBACK and REFILL wait on the memory ack
    // FILL writes the allocated line
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL
    } ctrl_state_t;

endpackage : cache_ctrl_pkg

//--- logic/data_cache_way.sv
//----------------------------------------------------------
// Data cache way
// Valid, dirty, tag and word storage of one way, read
// combinationally by set and written on the clock edge
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module data_cache_way (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  cache_types_pkg::index_t  index_i,
    input  logic                     wr_en_i,
    input  logic                     set_valid_i,
    input  logic                     dirty_i,
    input  cache_types_pkg::tag_t    tag_i,
    input  cache_types_pkg::word_t   data_i,
    output logic                     valid_o,
    output logic                     dirty_o,
    output cache_types_pkg::tag_t    tag_o,
    output cache_types_pkg::word_t   data_o
);

    import cache_types_pkg::*;

    // Status bits, one per set
    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;

    // Tag and word payload, one entry per set
    tag_t  tag_q  [`DC_SETS];
    word_t data_q [`DC_SETS];

    // Status bits start cleared so every set begins empty
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en_i) begin
            valid_q[index_i] <= set_valid_i;
            dirty_q[index_i] <= dirty_i;
        end
    end

    // Tag and word follow the same write strobe
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[index_i]  <= tag_i;
            data_q[index_i] <= data_i;
        end
    end

    // The current set is presented without a clock delay
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tag_q[index_i];
    assign data_o  = data_q[index_i];

endmodule : data_cache_way

//--- logic/data_cache_hit_check.sv
//----------------------------------------------------------
// Data cache hit check
// Compares the request tag against every way and selects
// the hit word and the victim line for writeback
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module data_cache_hit_check (
    input  cache_types_pkg::word_t [`DC_WAYS-1:0] cache_data_i,
    input  cache_types_pkg::tag_t  [`DC_WAYS-1:0] cache_tag_i,
    input  logic                   [`DC_WAYS-1:0] cache_valid_i,
    input  logic                   [`DC_WAYS-1:0] cache_dirty_i,
    input  cache_types_pkg::tag_t                 address_tag_i,
    input  cache_types_pkg::way_idx_t             way_select_i,
    output logic                                  hit_o,
    output logic                   [`DC_WAYS-1:0] way_hit_o,
    output cache_types_pkg::word_t                cache_data_o,
    output cache_types_pkg::word_t                cache_data_writeback_o,
    output cache_types_pkg::tag_t                 victim_tag_o,
    output logic                                  victim_dirty_o
);

    import cache_types_pkg::*;

    logic [`DC_WAYS-1:0] way_hit;
    way_idx_t            data_select;

    // A way hits only if its line is valid and the tags agree
    // At most one way can hit, so the last match wins harmlessly
    always_comb begin
        way_hit     = '0;
        data_select = '0;
        for (int i = 0; i < `DC_WAYS; i++) begin
            way_hit[i] = cache_valid_i[i] && (cache_tag_i[i] == address_tag_i);
            if (way_hit[i]) begin
                data_select = way_idx_t'(i);
            end
        end
    end

    assign hit_o     = |way_hit;
    assign way_hit_o = way_hit;

    // Word returned to the CPU on a hit
    assign cache_data_o = cache_data_i[data_select];

    // Victim line chosen by the replacement pointer
    assign cache_data_writeback_o = cache_data_i[way_select_i];
    assign victim_tag_o           = cache_tag_i[way_select_i];
    assign victim_dirty_o         = cache_dirty_i[way_select_i];

endmodule : data_cache_hit_check

//--- logic/data_cache_controller.sv
//----------------------------------------------------------
// Data cache controller
// Sequences lookup, writeback, refill and fill, keeps one
// round-robin victim pointer per set and drives the ways
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module data_cache_controller (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // CPU request
    input  logic                       req_i,
    input  logic                       we_i,
    input  cache_types_pkg::addr_t     addr_i,
    input  cache_types_pkg::word_t     wdata_i,
    output logic                       ready_o,
    output logic                       done_o,
    output logic                       hit_o,
    output cache_types_pkg::word_t     rdata_o,
    // Results from the hit checker
    input  logic                       hit_i,
    input  logic [`DC_WAYS-1:0]        way_hit_i,
    input  cache_types_pkg::word_t     hit_data_i,
    input  cache_types_pkg::word_t     victim_data_i,
    input  cache_types_pkg::tag_t      victim_tag_i,
    input  logic                       victim_dirty_i,
    // Common controls of the ways
    output cache_types_pkg::index_t    index_o,
    output cache_types_pkg::tag_t      tag_o,
    output cache_types_pkg::way_idx_t  way_select_o,
    output logic [`DC_WAYS-1:0]        way_wr_en_o,
    output logic                       way_dirty_o,
    output cache_types_pkg::word_t     way_data_o,
    // Memory side
    output logic                       mem_rd_o,
    output logic                       mem_wr_o,
    output cache_types_pkg::addr_t     mem_addr_o,
    output cache_types_pkg::word_t     mem_wdata_o,
    input  logic                       mem_ack_i,
    input  cache_types_pkg::word_t     mem_rdata_i
);

    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t state_q;

    // Registered request; the word doubles as the refill data
    logic   req_we_q;
    addr_t  req_addr_q;
    word_t  req_data_q;

    // Completion outputs
    logic   done_q;
    logic   hit_q;
    word_t  rdata_q;

    // Memory strobes and the values held until the ack
    logic   mem_rd_q;
    logic   mem_wr_q;
    addr_t  mem_addr_q;
    word_t  mem_wdata_q;

    // One round-robin victim pointer per set
    way_idx_t rr_ptr_q [`DC_SETS];

    tag_t                req_tag;
    index_t              req_index;
    way_idx_t            victim_way;
    logic [`DC_WAYS-1:0] victim_onehot;
    logic                accept;
    logic                alloc;

    //----------------------------------------------------------
    // Address split and victim choice
    //----------------------------------------------------------

    assign req_tag   = req_addr_q[`DC_ADDR_WIDTH-1 -: `DC_TAG_BITS];
    assign req_index = req_addr_q[`DC_INDEX_BITS-1:0];

    // The pointer only moves on a fill, so the victim stays put
    // through the whole writeback and refill sequence
    assign victim_way    = rr_ptr_q[req_index];
    assign victim_onehot = {{(`DC_WAYS-1){1'b0}}, 1'b1} << victim_way;

    // Ready drops for the done cycle so the next request
    // is taken only once the previous one has completed
    assign ready_o = (state_q == IDLE) && !done_q;
    assign accept  = req_i && ready_o;

    //----------------------------------------------------------
    // Way write port
    //----------------------------------------------------------

    always_comb begin
        way_wr_en_o = '0;
        way_dirty_o = 1'b0;
        alloc       = 1'b0;
        case (state_q)
            LOOKUP: begin
                if (req_we_q && hit_i) begin
                    // Store hit updates the hitting way in place
                    way_wr_en_o = way_hit_i;
                    way_dirty_o = 1'b1;
                end else if (req_we_q && !victim_dirty_i) begin
                    // Store miss over a clean victim allocates at once
                    way_wr_en_o = victim_onehot;
                    way_dirty_o = 1'b1;
                    alloc       = 1'b1;
                end
            end
            FILL: begin
                // Store data stays dirty, refilled data is clean
                way_wr_en_o = victim_onehot;
                way_dirty_o = req_we_q;
                alloc       = 1'b1;
            end
            default: begin
                way_wr_en_o = '0;
            end
        endcase
    end

    //----------------------------------------------------------
    // Request state machine
    //----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            done_q   <= 1'b0;
            hit_q    <= 1'b0;
            mem_rd_q <= 1'b0;
            mem_wr_q <= 1'b0;
            for (int s = 0; s < `DC_SETS; s++) begin
                rr_ptr_q[s] <= '0;
            end
        end else begin
            // Done and memory strobes are single-cycle pulses
            done_q   <= 1'b0;
            mem_rd_q <= 1'b0;
            mem_wr_q <= 1'b0;

            if (alloc) begin
                rr_ptr_q[req_index] <= rr_ptr_q[req_index] + 1'b1;
            end

            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    hit_q <= hit_i;
                    if (hit_i || (req_we_q && !victim_dirty_i)) begin
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end else if (victim_dirty_i) begin
                        mem_wr_q <= 1'b1;
                        state_q  <= WRITEBACK;
                    end else begin
                        mem_rd_q <= 1'b1;
                        state_q  <= REFILL;
                    end
                end
                WRITEBACK: begin
                    // A load still needs its word after the writeback
                    if (mem_ack_i && req_we_q) begin
                        state_q <= FILL;
                    end else if (mem_ack_i) begin
                        mem_rd_q <= 1'b1;
                        state_q  <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_ack_i) begin
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    done_q  <= 1'b1;
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    //----------------------------------------------------------
    // Request and memory payload
    //----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_we_q   <= we_i;
            req_addr_q <= addr_i;
            req_data_q <= wdata_i;
        end
        if (state_q == LOOKUP) begin
            rdata_q     <= hit_data_i;
            mem_wdata_q <= victim_data_i;
            // Writeback goes to the victim's own address
            mem_addr_q  <= victim_dirty_i ? {victim_tag_i, req_index} : req_addr_q;
        end
        if ((state_q == WRITEBACK) && mem_ack_i) begin
            mem_addr_q <= req_addr_q;
        end
        // Refill word is both written to the line and returned
        if ((state_q == REFILL) && mem_ack_i) begin
            req_data_q <= mem_rdata_i;
            rdata_q    <= mem_rdata_i;
        end
    end

    assign done_o      = done_q;
    assign hit_o       = hit_q;
    assign rdata_o     = rdata_q;

    assign index_o      = req_index;
    assign tag_o        = req_tag;
    assign way_select_o = victim_way;
    assign way_data_o   = req_data_q;

    assign mem_rd_o    = mem_rd_q;
    assign mem_wr_o    = mem_wr_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

endmodule : data_cache_controller

//--- logic/data_cache_top.sv
//----------------------------------------------------------
// Data cache top level
// Controller, four ways and the hit checker of a write-back
// set-associative cache
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module data_cache_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // CPU port
    input  logic                    req_i,
    input  logic                    we_i,
    input  cache_types_pkg::addr_t  addr_i,
    input  cache_types_pkg::word_t  wdata_i,
    output logic                    ready_o,
    output logic                    done_o,
    output logic                    hit_o,
    output cache_types_pkg::word_t  rdata_o,
    // Memory port
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output cache_types_pkg::addr_t  mem_addr_o,
    output cache_types_pkg::word_t  mem_wdata_o,
    input  logic                    mem_ack_i,
    input  cache_types_pkg::word_t  mem_rdata_i
);

    import cache_types_pkg::*;

    // Controller to ways
    index_t              index;
    tag_t                tag;
    way_idx_t            way_select;
    logic [`DC_WAYS-1:0] way_wr_en;
    logic                way_dirty;
    word_t               way_data;

    // Ways to hit checker
    logic [`DC_WAYS-1:0] rd_valid;
    logic [`DC_WAYS-1:0] rd_dirty;
    tag_t  [`DC_WAYS-1:0] rd_tag;
    word_t [`DC_WAYS-1:0] rd_data;

    // Hit checker to controller
    logic                hit;
    logic [`DC_WAYS-1:0] way_hit;
    word_t               hit_data;
    word_t               victim_data;
    tag_t                victim_tag;
    logic                victim_dirty;

    data_cache_controller controller_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .ready_o        (ready_o),
        .done_o         (done_o),
        .hit_o          (hit_o),
        .rdata_o        (rdata_o),
        .hit_i          (hit),
        .way_hit_i      (way_hit),
        .hit_data_i     (hit_data),
        .victim_data_i  (victim_data),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .index_o        (index),
        .tag_o          (tag),
        .way_select_o   (way_select),
        .way_wr_en_o    (way_wr_en),
        .way_dirty_o    (way_dirty),
        .way_data_o     (way_data),
        .mem_rd_o       (mem_rd_o),
        .mem_wr_o       (mem_wr_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i)
    );

    // Every write allocates or updates a live line, so valid is always set
    for (genvar w = 0; w < `DC_WAYS; w++) begin : gen_way
        data_cache_way way_i (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .index_i     (index),
            .wr_en_i     (way_wr_en[w]),
            .set_valid_i (1'b1),
            .dirty_i     (way_dirty),
            .tag_i       (tag),
            .data_i      (way_data),
            .valid_o     (rd_valid[w]),
            .dirty_o     (rd_dirty[w]),
            .tag_o       (rd_tag[w]),
            .data_o      (rd_data[w])
        );
    end

    data_cache_hit_check hit_check_i (
        .cache_data_i           (rd_data),
        .cache_tag_i            (rd_tag),
        .cache_valid_i          (rd_valid),
        .cache_dirty_i          (rd_dirty),
        .address_tag_i          (tag),
        .way_select_i           (way_select),
        .hit_o                  (hit),
        .way_hit_o              (way_hit),
        .cache_data_o           (hit_data),
        .cache_data_writeback_o (victim_data),
        .victim_tag_o           (victim_tag),
        .victim_dirty_o         (victim_dirty)
    );

endmodule : data_cache_top

//--- verif/tb_memory_model.sv
//----------------------------------------------------------
// Backing memory model
// Word memory with a preset pattern, a random ack delay of
// one to four cycles and a written flag per address
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module tb_memory_model (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    rd_i,
    input  logic                    wr_i,
    input  cache_types_pkg::addr_t  addr_i,
    input  cache_types_pkg::word_t  wdata_i,
    output logic                    ack_o,
    output cache_types_pkg::word_t  rdata_o
);

    import cache_types_pkg::*;

    word_t       mem     [1 << `DC_ADDR_WIDTH];
    logic        written [1 << `DC_ADDR_WIDTH];
    logic        busy;
    logic [2:0]  count;
    addr_t       addr_q;
    logic [31:0] rng;

    // Preset content mixes every address bit into the word
    function automatic word_t preset_word(input addr_t a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    // One xorshift step of the delay generator
    function automatic logic [31:0] advance_rng();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    initial begin
        for (int a = 0; a < (1 << `DC_ADDR_WIDTH); a++) begin
            mem[a]     = preset_word(addr_t'(a));
            written[a] = 1'b0;
        end
        rng      = 32'h751c_f833;
        ack_o    = 1'b0;
        rdata_o  = '0;
        busy     = 1'b0;
        count    = 3'd0;
        addr_q   = '0;
    end

    // Strobes are sampled and ack is driven on the falling edge
    always @(negedge clk_i) begin
        ack_o <= 1'b0;
        if (!rst_n_i) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (count == 3'd1) begin
                ack_o   <= 1'b1;
                rdata_o <= mem[addr_q];
                busy    <= 1'b0;
            end else begin
                count <= count - 3'd1;
            end
        end else if (rd_i || wr_i) begin
            busy   <= 1'b1;
            count  <= 3'(advance_rng() % 32'd4) + 3'd1;
            addr_q <= addr_i;
            if (wr_i) begin
                // Writebacks land at once and are recorded
                mem[addr_i]     <= wdata_i;
                written[addr_i] <= 1'b1;
            end
        end
    end

endmodule : tb_memory_model

//--- verif/tb_data_cache.sv
//----------------------------------------------------------
// Data cache testbench
// Random loads and stores against a shadow memory and a
// shadow tag store with round-robin victims
//----------------------------------------------------------

`timescale 1ns/1ns

`include "data_cache_params.svh"

module tb_data_cache;

    import cache_types_pkg::*;

    localparam int NUM_REQ = 600;

    logic  clk, rst_n, req, we, ready, done, hit;
    logic  mem_rd, mem_wr, mem_ack;
    addr_t addr, mem_addr;
    word_t wdata, rdata, mem_wdata, mem_rdata;

    // Shadow memory and shadow tag store
    word_t       sh_mem   [1 << `DC_ADDR_WIDTH];
    logic        sh_valid [`DC_SETS][`DC_WAYS];
    logic        sh_dirty [`DC_SETS][`DC_WAYS];
    tag_t        sh_tag   [`DC_SETS][`DC_WAYS];
    way_idx_t    sh_rr    [`DC_SETS];
    // Set once the CPU has stored to the address
    logic        sh_stored [1 << `DC_ADDR_WIDTH];
    logic [31:0] rng_state;
    int          cycle_cnt;
    int          completed;

    // Expectations of the outstanding request
    logic  exp_we_q[$];
    logic  exp_hit_q[$];
    word_t exp_rdata_q[$];
    int    exp_edge_q[$];
    logic  wb_pending;
    addr_t wb_addr;
    word_t wb_data;

    data_cache_top data_cache_top_i (
        .clk_i (clk), .rst_n_i (rst_n), .req_i (req), .we_i (we),
        .addr_i (addr), .wdata_i (wdata), .ready_o (ready), .done_o (done),
        .hit_o (hit), .rdata_o (rdata), .mem_rd_o (mem_rd), .mem_wr_o (mem_wr),
        .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata),
        .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata)
    );

    tb_memory_model memory_i (
        .clk_i (clk), .rst_n_i (rst_n), .rd_i (mem_rd), .wr_i (mem_wr),
        .addr_i (mem_addr), .wdata_i (mem_wdata), .ack_o (mem_ack), .rdata_o (mem_rdata)
    );

    //----------------------------------------------------------
    // Helpers
    //----------------------------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // Predicts hit or miss, the victim writeback and the read value,
    // then updates the shadow state as the access demands
    function automatic word_t reference_access(input logic w, input addr_t a,
                                               input word_t d, output logic h);
        index_t   s;
        tag_t     t;
        way_idx_t v;
        word_t    result;
        s = a[`DC_INDEX_BITS-1:0];
        t = a[`DC_ADDR_WIDTH-1 -: `DC_TAG_BITS];
        h = 1'b0;
        v = '0;
        for (int i = 0; i < `DC_WAYS; i++) begin
            if (sh_valid[s][i] && sh_tag[s][i] == t) begin
                h = 1'b1;
                v = way_idx_t'(i);
            end
        end
        if (!h) begin
            v = sh_rr[s];
            if (sh_valid[s][v] && sh_dirty[s][v]) begin
                wb_pending = 1'b1;
                wb_addr    = {sh_tag[s][v], s};
                wb_data    = sh_mem[{sh_tag[s][v], s}];
            end
            sh_valid[s][v] = 1'b1;
            sh_tag[s][v]   = t;
            sh_dirty[s][v] = 1'b0;
            sh_rr[s]       = sh_rr[s] + 2'd1;
        end
        if (w) begin
            sh_dirty[s][v] = 1'b1;
            sh_mem[a]      = d;
            sh_stored[a]   = 1'b1;
        end
        result = sh_mem[a];
        return result;
    endfunction

    // Every address not held dirty in the cache must hold its latest
    // value in the backing memory, and only stored lines were written back
    task automatic check_backing_memory();
        index_t s;
        tag_t   t;
        logic   held;
        for (int a = 0; a < (1 << `DC_ADDR_WIDTH); a++) begin
            s    = index_t'(a);
            t    = tag_t'(a >> `DC_INDEX_BITS);
            held = 1'b0;
            for (int i = 0; i < `DC_WAYS; i++) begin
                if (sh_valid[s][i] && sh_dirty[s][i] && sh_tag[s][i] == t) begin
                    held = 1'b1;
                end
            end
            if (!held) begin
                check_equal("memory word", memory_i.mem[a], sh_mem[a]);
                check_equal("memory written flag", word_t'(memory_i.written[a]),
                            word_t'(sh_stored[a]));
            end
        end
    endtask

    //----------------------------------------------------------
    // Clock, reset and watchdog
    //----------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Each request gets twenty cycles before the run is declared hung
    initial begin
        repeat ((NUM_REQ + 5) * 20) @(posedge clk);
        report_failure($sformatf("Timeout: only %0d of %0d requests completed",
                                 completed, NUM_REQ));
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------

    initial begin
        logic [31:0] r;
        logic        h;
        word_t       exp_rd;
        int          issued;
        rst_n = 1'b0;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        rng_state = 32'h751c_f833;
        cycle_cnt = 0;
        completed = 0;
        issued = 0;
        wb_pending = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int a = 0; a < (1 << `DC_ADDR_WIDTH); a++) begin
            sh_mem[a]    = {16'(a) ^ 16'hc3a5, ~16'(a)};
            sh_stored[a] = 1'b0;
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            sh_rr[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_equal("ready_o", word_t'(ready), 32'd1);
        check_equal("mem_rd_o", word_t'(mem_rd), 32'd0);
        check_equal("mem_wr_o", word_t'(mem_wr), 32'd0);
        while (issued < NUM_REQ) begin
            @(negedge clk);
            r = next_random();
            if (ready && r[2:0] != 3'd0) begin
                // Six tags per set against four ways forces evictions
                we    = r[8];
                addr  = {tag_t'(r[31:16] % 16'd6), r[7:4]};
                wdata = next_random();
                req   = 1'b1;
                exp_rd = reference_access(we, addr, wdata, h);
                exp_we_q.push_back(we);
                exp_hit_q.push_back(h);
                exp_rdata_q.push_back(exp_rd);
                exp_edge_q.push_back(cycle_cnt + 2);
                issued++;
            end else if (!ready && r[3]) begin
                // Junk store that must be ignored while busy
                we    = 1'b1;
                addr  = addr_t'(r[31:16]);
                wdata = next_random();
                req   = 1'b1;
            end else begin
                req = 1'b0;
            end
        end
        @(negedge clk);
        req = 1'b0;
        wait (completed == NUM_REQ);
        repeat (4) @(negedge clk);
        check_backing_memory();
        $display("*** PASSED ***");
        $finish;
    end

    //----------------------------------------------------------
    // Response checks, sampled on the falling edge
    //----------------------------------------------------------

    always @(negedge clk) begin
        if (rst_n && mem_wr) begin
            if (!wb_pending) begin
                report_failure("A clean or unexpected line was written back to memory");
            end
            check_equal("mem_addr_o", word_t'(mem_addr), word_t'(wb_addr));
            check_equal("mem_wdata_o", mem_wdata, wb_data);
            wb_pending = 1'b0;
        end
        if (rst_n && done) begin
            if (exp_we_q.size() == 0) begin
                report_failure("done_o pulsed without an accepted request");
            end
            if (wb_pending) begin
                report_failure("Request completed without its dirty writeback");
            end
            check_equal("hit_o", word_t'(hit), word_t'(exp_hit_q[0]));
            if (!exp_we_q[0]) begin
                check_equal("rdata_o", rdata, exp_rdata_q[0]);
            end
            // Hits complete exactly two cycles after acceptance
            if (exp_hit_q[0]) begin
                check_equal("done_o cycle", word_t'(cycle_cnt), word_t'(exp_edge_q[0]));
            end
            void'(exp_we_q.pop_front());
            void'(exp_hit_q.pop_front());
            void'(exp_rdata_q.pop_front());
            void'(exp_edge_q.pop_front());
            completed++;
        end
    end

endmodule : tb_data_cache

//--- sim.f
+incdir+logic
logic/cache_types_pkg.sv
logic/cache_ctrl_pkg.sv
logic/data_cache_way.sv
logic/data_cache_hit_check.sv
logic/data_cache_controller.sv
logic/data_cache_top.sv
verif/tb_memory_model.sv
verif/tb_data_cache.sv

//--- run_sim.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it.
# The verdict comes from the pass message in the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f sim.f --top-module tb_data_cache --Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_data_cache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
